/* if_stage_top.f */
+incdir+rtl
rtl/if_stage_pkg.sv
rtl/if_id_if.sv
rtl/pc_select.sv
rtl/if_id_pipe.sv
rtl/pc_incr_check.sv
rtl/if_stage_top.sv
verif/if_stage_assertions.sv
verif/if_stage_tb.sv

/* rtl/if_id_if.sv */
//////////////////////////////////////////////////
// IF/ID state bundle
// pipeline register outputs toward the pc check
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface if_id_if;
  import if_stage_pkg::*;

  // current fetch address, not yet registered
  addr_t pc_if;
  // registered pc and compressed flag of the ID instruction
  addr_t pc_id;
  logic  compressed_id;
  // beat taken this cycle
  logic  accept;
  // merged bus / pmp error of the current beat
  logic  fetch_err;

  // pipeline register side
  modport pipe_mp (
    output pc_if, pc_id, compressed_id, accept, fetch_err
  );

  // pc increment checker side
  modport check_mp (
    input pc_if, pc_id, compressed_id, accept, fetch_err
  );

endinterface

/* rtl/if_id_pipe.sv */
//////////////////////////////////////////////////
// IF/ID pipeline register
// error merging, compressed test, valid/new flags
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "if_stage_params.svh"

module if_id_pipe (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_valid_i,
  input  if_stage_pkg::instr_t fetch_rdata_i,
  input  if_stage_pkg::addr_t  fetch_addr_i,
  input  logic                 fetch_err_i,
  input  logic                 fetch_err_plus2_i,
  input  logic                 pmp_err_if_i,
  input  logic                 pmp_err_if_plus2_i,
  input  logic                 id_in_ready_i,
  input  logic                 pc_set_i,
  input  logic                 instr_valid_clear_i,
  output logic                 fetch_ready_o,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output if_stage_pkg::instr_t instr_rdata_id_o,
  output if_stage_pkg::half_t  instr_rdata_c_id_o,
  output logic                 instr_is_compressed_id_o,
  output logic                 instr_fetch_err_o,
  output logic                 instr_fetch_err_plus2_o,
  output if_stage_pkg::addr_t  pc_id_o,
  if_id_if.pipe_mp             if_id
);
  import if_stage_pkg::*;

  logic  is_compressed;
  logic  pmp_err_plus2;
  logic  pmp_err;
  logic  instr_err;
  logic  instr_err_plus2;
  logic  accept;
  logic  valid_d;
  half_t rdata_c;

  // rvc encodings never have both low bits set
  assign is_compressed = (fetch_rdata_i[1:0] != 2'b11);
  assign rdata_c       = fetch_rdata_i[`IF_XLEN/2-1:0];

  //////////////////////////////////////////////////
  // error merging
  //////////////////////////////////////////////////

  // 32-bit instr straddling a word, second half faulted
  assign pmp_err_plus2 = fetch_addr_i[1] & ~is_compressed & pmp_err_if_plus2_i;
  assign pmp_err       = pmp_err_if_i | pmp_err_plus2;
  assign instr_err     = fetch_err_i | pmp_err;
  // fault on the first half wins over the second
  assign instr_err_plus2 = (pmp_err_plus2 | fetch_err_plus2_i) & ~pmp_err_if_i;

  // no stall source besides ID
  assign fetch_ready_o = id_in_ready_i;
  assign accept        = fetch_valid_i & id_in_ready_i;

  // pc_set squashes the beat taken in the same cycle
  assign valid_d = (accept & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // one pulse per accepted beat
      instr_new_id_o   <= accept;
    end
  end

  // data registers, frozen under back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o         <= '0;
      instr_rdata_c_id_o       <= '0;
      instr_is_compressed_id_o <= 1'b0;
      instr_fetch_err_o        <= 1'b0;
      instr_fetch_err_plus2_o  <= 1'b0;
      pc_id_o                  <= '0;
    end else if (accept) begin
      instr_rdata_id_o         <= fetch_rdata_i;
      instr_rdata_c_id_o       <= rdata_c;
      instr_is_compressed_id_o <= is_compressed;
      instr_fetch_err_o        <= instr_err;
      instr_fetch_err_plus2_o  <= instr_err_plus2;
      pc_id_o                  <= fetch_addr_i;
    end
  end

  // state for the pc check
  assign if_id.pc_if         = fetch_addr_i;
  assign if_id.pc_id         = pc_id_o;
  assign if_id.compressed_id = instr_is_compressed_id_o;
  assign if_id.accept        = accept;
  assign if_id.fetch_err     = instr_err;

endmodule

/* rtl/if_stage_params.svh */
//////////////////////////////////////////////////
// fetch stage constants
// debug addresses, boot offset and vector layout
//////////////////////////////////////////////////

`ifndef IF_STAGE_PARAMS_SVH
`define IF_STAGE_PARAMS_SVH

// datapath width
`define IF_XLEN 32

// debug module entry points
`define IF_DM_HALT_ADDR 32'h1A11_0800
`define IF_DM_EXC_ADDR  32'h1A11_0808

// first fetch lands this far into the boot page
`define IF_BOOT_OFFSET 8'h80

// low bits of mtvec ignored for the trap base
`define IF_VEC_ALIGN 8

// vector slot shared by all internal interrupts
`define IF_NMI_CAUSE 5'd31

`endif

/* rtl/if_stage_pkg.sv */
//////////////////////////////////////////////////
// instruction fetch stage shared types
// pc source selects, exception cause and word types
//////////////////////////////////////////////////

package if_stage_pkg;

  // byte address and raw instruction words
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  // low half, kept for mtval on compressed instructions
  typedef logic [15:0] half_t;

  //////////////////////////////////////////////////
  // next-pc sources
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    pc_boot = 3'd0,
    pc_jump = 3'd1,
    pc_exc  = 3'd2,
    pc_eret = 3'd3,
    pc_dret = 3'd4
  } pc_sel_e;

  // trap target within the exception path
  typedef enum logic [1:0] {
    exc_pc_exc     = 2'd0,
    exc_pc_irq     = 2'd1,
    exc_pc_dbd     = 2'd2,
    exc_pc_dbg_exc = 2'd3
  } exc_pc_sel_e;

  // interrupt / exception cause as seen by the vector logic
  typedef struct packed {
    logic       irq_int;
    logic       irq_ext;
    logic [4:0] lower_cause;
  } exc_cause_t;

endpackage

/* rtl/if_stage_top.sv */
//////////////////////////////////////////////////
// instruction fetch stage top
// pc select, IF/ID register and pc increment check
//////////////////////////////////////////////////

`timescale 1ns/1ps

module if_stage_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // redirect sources
  input  if_stage_pkg::addr_t       boot_addr_i,
  input  if_stage_pkg::addr_t       branch_target_ex_i,
  input  if_stage_pkg::addr_t       csr_mepc_i,
  input  if_stage_pkg::addr_t       csr_depc_i,
  input  if_stage_pkg::addr_t       csr_mtvec_i,
  // redirect control
  input  logic                      pc_set_i,
  input  if_stage_pkg::pc_sel_e     pc_mux_i,
  input  if_stage_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_stage_pkg::exc_cause_t  exc_cause_i,
  // fetch stream from the prefetcher
  input  logic                      fetch_valid_i,
  input  if_stage_pkg::instr_t      fetch_rdata_i,
  input  if_stage_pkg::addr_t       fetch_addr_i,
  input  logic                      fetch_err_i,
  input  logic                      fetch_err_plus2_i,
  input  logic                      pmp_err_if_i,
  input  logic                      pmp_err_if_plus2_i,
  // ID stage control
  input  logic                      id_in_ready_i,
  input  logic                      instr_valid_clear_i,
  // prefetcher redirect
  output logic                      prefetch_branch_o,
  output if_stage_pkg::addr_t       prefetch_addr_o,
  output logic                      csr_mtvec_init_o,
  output logic                      fetch_ready_o,
  // ID stage instruction
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output if_stage_pkg::instr_t      instr_rdata_id_o,
  output if_stage_pkg::half_t       instr_rdata_c_id_o,
  output logic                      instr_is_compressed_id_o,
  output logic                      instr_fetch_err_o,
  output logic                      instr_fetch_err_plus2_o,
  output if_stage_pkg::addr_t       pc_if_o,
  output if_stage_pkg::addr_t       pc_id_o,
  output logic                      pc_mismatch_alert_o
);

  // IF/ID state toward the checker
  if_id_if if_id ();

  pc_select u_pc_select (
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_cause_i        (exc_cause_i),
    .prefetch_branch_o  (prefetch_branch_o),
    .prefetch_addr_o    (prefetch_addr_o),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  if_id_pipe u_if_id_pipe (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .fetch_valid_i            (fetch_valid_i),
    .fetch_rdata_i            (fetch_rdata_i),
    .fetch_addr_i             (fetch_addr_i),
    .fetch_err_i              (fetch_err_i),
    .fetch_err_plus2_i        (fetch_err_plus2_i),
    .pmp_err_if_i             (pmp_err_if_i),
    .pmp_err_if_plus2_i       (pmp_err_if_plus2_i),
    .id_in_ready_i            (id_in_ready_i),
    .pc_set_i                 (pc_set_i),
    .instr_valid_clear_i      (instr_valid_clear_i),
    .fetch_ready_o            (fetch_ready_o),
    .instr_valid_id_o         (instr_valid_id_o),
    .instr_new_id_o           (instr_new_id_o),
    .instr_rdata_id_o         (instr_rdata_id_o),
    .instr_rdata_c_id_o       (instr_rdata_c_id_o),
    .instr_is_compressed_id_o (instr_is_compressed_id_o),
    .instr_fetch_err_o        (instr_fetch_err_o),
    .instr_fetch_err_plus2_o  (instr_fetch_err_plus2_o),
    .pc_id_o                  (pc_id_o),
    .if_id                    (if_id.pipe_mp)
  );

  pc_incr_check u_pc_incr_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pc_set_i            (pc_set_i),
    .if_id               (if_id.check_mp),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // fetch address is the IF pc
  assign pc_if_o = fetch_addr_i;

endmodule

/* rtl/pc_incr_check.sv */
//////////////////////////////////////////////////
// pc increment check
// alerts on a non-sequential pc in sequential flow
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "if_stage_params.svh"

module pc_incr_check (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      pc_set_i,
  if_id_if.check_mp if_id,
  output logic      pc_mismatch_alert_o
);
  import if_stage_pkg::*;

  logic  seq_d;
  logic  seq_q;
  addr_t pc_expected;

  // flow stays sequential until a redirect or a faulted beat
  assign seq_d = (seq_q | if_id.accept) & ~pc_set_i & ~(if_id.accept & if_id.fetch_err);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  // step size from the ID instruction
  assign pc_expected = if_id.pc_id + (if_id.compressed_id ? `IF_XLEN'd2 : `IF_XLEN'd4);

  // any other fetch address is a control flow fault
  assign pc_mismatch_alert_o = seq_q & (if_id.pc_if != pc_expected);

endmodule

/* rtl/pc_select.sv */
//////////////////////////////////////////////////
// next-pc selection
// exception vector mux, fetch redirect, mtvec init
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "if_stage_params.svh"

module pc_select (
  input  if_stage_pkg::addr_t       boot_addr_i,
  input  if_stage_pkg::addr_t       branch_target_ex_i,
  input  if_stage_pkg::addr_t       csr_mepc_i,
  input  if_stage_pkg::addr_t       csr_depc_i,
  input  if_stage_pkg::addr_t       csr_mtvec_i,
  input  logic                      pc_set_i,
  input  if_stage_pkg::pc_sel_e     pc_mux_i,
  input  if_stage_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_stage_pkg::exc_cause_t  exc_cause_i,
  output logic                      prefetch_branch_o,
  output if_stage_pkg::addr_t       prefetch_addr_o,
  output logic                      csr_mtvec_init_o
);
  import if_stage_pkg::*;

  addr_t      trap_base;
  addr_t      boot_pc;
  addr_t      exc_pc;
  addr_t      next_pc;
  logic [4:0] irq_vec;

  // mtvec with the mode / alignment bits dropped
  assign trap_base = {csr_mtvec_i[`IF_XLEN-1:`IF_VEC_ALIGN], {`IF_VEC_ALIGN{1'b0}}};

  // boot base is page aligned, offset sits in the low byte
  assign boot_pc = {boot_addr_i[`IF_XLEN-1:8], `IF_BOOT_OFFSET};

  //////////////////////////////////////////////////
  // exception vector
  //////////////////////////////////////////////////

  always_comb begin
    irq_vec = exc_cause_i.lower_cause;
    // internal irqs all share the nmi slot
    if (exc_cause_i.irq_int) begin
      irq_vec = `IF_NMI_CAUSE;
    end

    unique case (exc_pc_mux_i)
      exc_pc_exc:     exc_pc = trap_base;
      // vectored mode, one word per cause
      exc_pc_irq:     exc_pc = trap_base + addr_t'({irq_vec, 2'b00});
      exc_pc_dbd:     exc_pc = `IF_DM_HALT_ADDR;
      exc_pc_dbg_exc: exc_pc = `IF_DM_EXC_ADDR;
      default:        exc_pc = trap_base;
    endcase
  end

  //////////////////////////////////////////////////
  // next pc
  //////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      pc_boot: next_pc = boot_pc;
      pc_jump: next_pc = branch_target_ex_i;
      pc_exc:  next_pc = exc_pc;
      // return from trap / debug
      pc_eret: next_pc = csr_mepc_i;
      pc_dret: next_pc = csr_depc_i;
      default: next_pc = boot_pc;
    endcase
  end

  // redirect the prefetcher on every pc set
  assign prefetch_branch_o = pc_set_i;
  // halfword aligned target
  assign prefetch_addr_o   = {next_pc[`IF_XLEN-1:1], 1'b0};

  // csr file loads its mtvec reset value on boot
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == pc_boot);

endmodule

/* verif/if_stage_assertions.sv */
//////////////////////////////////////////////////
// fetch stage port assertions
// bound to the top level, select and flag rules
//////////////////////////////////////////////////

`timescale 1ns/1ps

module if_stage_assertions (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      pc_set_i,
  input if_stage_pkg::exc_pc_sel_e exc_pc_mux_i,
  input logic                      csr_mtvec_init_o,
  input logic                      prefetch_branch_o,
  input if_stage_pkg::addr_t       prefetch_addr_o,
  input logic                      instr_new_id_o,
  input logic                      instr_valid_id_o
);
  import if_stage_pkg::*;

  // exception select never floats
  a_exc_sel_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(exc_pc_mux_i)) else $error("exc_pc_mux_i is unknown");

  // mtvec init only on a redirect
  a_mtvec_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o |-> pc_set_i) else $error("mtvec init without pc_set_i");

  // branch target is halfword aligned
  a_branch_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
    prefetch_branch_o |-> !prefetch_addr_o[0]) else $error("odd branch address");

  // new instruction is valid unless squashed by a redirect
  a_new_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> (instr_valid_id_o || $past(pc_set_i)))
    else $error("new instruction without valid");

endmodule

bind if_stage_top if_stage_assertions u_if_stage_assertions (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .pc_set_i          (pc_set_i),
  .exc_pc_mux_i      (exc_pc_mux_i),
  .csr_mtvec_init_o  (csr_mtvec_init_o),
  .prefetch_branch_o (prefetch_branch_o),
  .prefetch_addr_o   (prefetch_addr_o),
  .instr_new_id_o    (instr_new_id_o),
  .instr_valid_id_o  (instr_valid_id_o)
);

/* verif/if_stage_tb.sv */
//////////////////////////////////////////////////
// fetch stage testbench
// random fetch stream and redirects vs cycle model
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "if_stage_params.svh"

module if_stage_tb;
  import if_stage_pkg::*;

  localparam int n_cycles = 3000;

  logic        clk_i, rst_ni, pc_set_i, fetch_valid_i, fetch_err_i, fetch_err_plus2_i;
  logic        pmp_err_if_i, pmp_err_if_plus2_i, id_in_ready_i, instr_valid_clear_i;
  addr_t       boot_addr_i, branch_target_ex_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  addr_t       fetch_addr_i, prefetch_addr_o, pc_if_o, pc_id_o;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  exc_cause_t  exc_cause_i;
  instr_t      fetch_rdata_i, instr_rdata_id_o;
  half_t       instr_rdata_c_id_o;
  logic        prefetch_branch_o, csr_mtvec_init_o, fetch_ready_o, instr_valid_id_o;
  logic        instr_new_id_o, instr_is_compressed_id_o, instr_fetch_err_o;
  logic        instr_fetch_err_plus2_o, pc_mismatch_alert_o;

  // model state, mirrors the IF/ID registers and the sequence flag
  logic        m_valid, m_new, m_comp, m_err, m_err2, m_seq;
  instr_t      m_rdata;
  addr_t       m_pc_id;
  // fetch address for the next beat, applied at the next falling edge
  addr_t       next_addr;

  if_stage_top dut_i (.*);

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input addr_t act, input addr_t exp, input string name);
    if (act !== exp) report_mismatch($sformatf("%s got %h expected %h", name, act, exp));
  endtask

  task automatic check_instr(input instr_t act, input instr_t exp, input string name);
    if (act !== exp) report_mismatch($sformatf("%s got %h expected %h", name, act, exp));
  endtask

  task automatic check_half(input half_t act, input half_t exp, input string name);
    if (act !== exp) report_mismatch($sformatf("%s got %h expected %h", name, act, exp));
  endtask

  task automatic check_bit(input logic act, input logic exp, input string name);
    if (act !== exp) report_mismatch($sformatf("%s got %b expected %b", name, act, exp));
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // trap vector, internal irqs go to the nmi slot
  function automatic addr_t exp_vector();
    addr_t       base;
    int unsigned slot;
    base = csr_mtvec_i & ~((32'd1 << `IF_VEC_ALIGN) - 32'd1);
    slot = exc_cause_i.irq_int ? `IF_NMI_CAUSE : exc_cause_i.lower_cause;
    case (exc_pc_mux_i)
      exc_pc_irq:     return base + addr_t'(4 * slot);
      exc_pc_dbd:     return `IF_DM_HALT_ADDR;
      exc_pc_dbg_exc: return `IF_DM_EXC_ADDR;
      default:        return base;
    endcase
  endfunction

  function automatic addr_t exp_next_pc();
    addr_t pc;
    case (pc_mux_i)
      pc_jump: pc = branch_target_ex_i;
      pc_exc:  pc = exp_vector();
      pc_eret: pc = csr_mepc_i;
      pc_dret: pc = csr_depc_i;
      default: pc = boot_addr_i + addr_t'(`IF_BOOT_OFFSET);
    endcase
    return pc & ~32'd1;
  endfunction

  // registered outputs, stable at the falling edge
  task automatic check_registered();
    check_bit(instr_valid_id_o, m_valid, "instr_valid_id_o");
    check_bit(instr_new_id_o, m_new, "instr_new_id_o");
    check_instr(instr_rdata_id_o, m_rdata, "instr_rdata_id_o");
    check_half(instr_rdata_c_id_o, m_rdata[15:0], "instr_rdata_c_id_o");
    check_bit(instr_is_compressed_id_o, m_comp, "instr_is_compressed_id_o");
    check_bit(instr_fetch_err_o, m_err, "instr_fetch_err_o");
    check_bit(instr_fetch_err_plus2_o, m_err2, "instr_fetch_err_plus2_o");
    check_addr(pc_id_o, m_pc_id, "pc_id_o");
  endtask

  task automatic check_comb();
    addr_t step;
    step = m_comp ? 32'd2 : 32'd4;
    check_bit(prefetch_branch_o, pc_set_i, "prefetch_branch_o");
    if (pc_set_i) check_addr(prefetch_addr_o, exp_next_pc(), "prefetch_addr_o");
    check_bit(csr_mtvec_init_o, pc_set_i && pc_mux_i == pc_boot, "csr_mtvec_init_o");
    check_bit(fetch_ready_o, id_in_ready_i, "fetch_ready_o");
    check_addr(pc_if_o, fetch_addr_i, "pc_if_o");
    check_bit(pc_mismatch_alert_o, m_seq && fetch_addr_i != m_pc_id + step,
              "pc_mismatch_alert_o");
  endtask

  // advance the model one clock, then pick the next fetch address
  task automatic update_model();
    logic acc, comp, pmp2, err, err2;
    acc  = fetch_valid_i && id_in_ready_i;
    comp = fetch_rdata_i[1:0] != 2'b11;
    pmp2 = fetch_addr_i[1] && !comp && pmp_err_if_plus2_i;
    err  = fetch_err_i || pmp_err_if_i || pmp2;
    err2 = (pmp2 || fetch_err_plus2_i) && !pmp_err_if_i;
    m_seq   = (m_seq || acc) && !pc_set_i && !(acc && err);
    m_valid = (acc && !pc_set_i) || (m_valid && !instr_valid_clear_i);
    m_new   = acc;
    if (acc) begin
      m_rdata = fetch_rdata_i;
      m_comp  = comp;
      m_err   = err;
      m_err2  = err2;
      m_pc_id = fetch_addr_i;
    end
    if (pc_set_i) begin
      next_addr = exp_next_pc();
    end else if (acc) begin
      // mostly sequential, now and then a jump
      if ($urandom % 16 == 0) next_addr = $urandom & ~32'd1;
      else next_addr = fetch_addr_i + (comp ? 32'd2 : 32'd4);
    end
  endtask

  task automatic drive_inputs();
    boot_addr_i         = $urandom & 32'hFFFF_FF00;
    branch_target_ex_i  = $urandom;
    csr_mepc_i          = $urandom;
    csr_depc_i          = $urandom;
    csr_mtvec_i         = $urandom;
    pc_mux_i            = pc_sel_e'($urandom % 8);
    exc_pc_mux_i        = exc_pc_sel_e'($urandom % 4);
    exc_cause_i         = exc_cause_t'($urandom);
    exc_cause_i.irq_int = ($urandom % 4 == 0);
    pc_set_i            = ($urandom % 10 == 0);
    fetch_valid_i       = ($urandom % 4 != 0);
    fetch_addr_i        = next_addr;
    fetch_rdata_i       = $urandom;
    if ($urandom % 2) fetch_rdata_i[1:0] = 2'b11;
    fetch_err_i         = ($urandom % 12 == 0);
    fetch_err_plus2_i   = ($urandom % 12 == 0);
    pmp_err_if_i        = ($urandom % 12 == 0);
    pmp_err_if_plus2_i  = ($urandom % 6 == 0);
    id_in_ready_i       = ($urandom % 5 != 0);
    instr_valid_clear_i = ($urandom % 3 == 0);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h5877));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {pc_set_i, fetch_valid_i, fetch_err_i, fetch_err_plus2_i} = '0;
    {pmp_err_if_i, pmp_err_if_plus2_i, id_in_ready_i, instr_valid_clear_i} = '0;
    {boot_addr_i, branch_target_ex_i, csr_mepc_i, csr_depc_i, csr_mtvec_i} = '0;
    fetch_addr_i  = '0;
    next_addr     = '0;
    fetch_rdata_i = '0;
    pc_mux_i      = pc_boot;
    exc_pc_mux_i  = exc_pc_exc;
    exc_cause_i   = '0;
    {m_valid, m_new, m_comp, m_err, m_err2, m_seq} = '0;
    m_rdata = '0;
    m_pc_id = '0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < n_cycles; i++) begin
      @(negedge clk_i);
      check_registered();
      drive_inputs();
      #1;
      check_comb();
      update_model();
    end
    $display("Test OK");
    $finish;
  end

  initial begin
    #((n_cycles + 10) * 20 * 2);
    $display("Timeout: simulation did not finish in time");
    $display("Test FAILED");
    $fatal(1);
  end

endmodule
